//--- include/readout_params.svh
`ifndef READOUT_PARAMS_SVH
`define READOUT_PARAMS_SVH

////////////////////////////////////////////////////////////
// Channel side
////////////////////////////////////////////////////////////
`define NUM_CHAN        4   // Front-end receiver channels
`define CHAN_DATA_W     24  // Payload bits per channel word
`define CHAN_ID_W       4   // Identifier field, index plus one
`define CHAN_FIFO_DEPTH 8   // Words per channel buffer

////////////////////////////////////////////////////////////
// Output side
////////////////////////////////////////////////////////////
`define OUT_FIFO_DEPTH  32  // Output FIFO words
`define NEAR_FULL_LEVEL 24  // Fill level for near-full
`define AXI_ADDR_W      8   // Byte address width
`define AXI_DATA_W      32  // AXI4-Lite data width

`endif

//--- logic/readout_pkg.sv
`include "readout_params.svh"

package readout_pkg;

  // Word as delivered by one receiver channel
  typedef struct packed {
    logic [`CHAN_DATA_W-1:0] data;  // Receiver payload
    logic                    last;  // Last word of packet
  } chan_word_t;

  // Merged word as the host reads it from DATA
  typedef struct packed {
    logic [`CHAN_ID_W-1:0]                         id;    // Channel index plus one
    logic                                          last;  // Bit 27
    logic [`AXI_DATA_W-`CHAN_ID_W-`CHAN_DATA_W-2:0] zero;  // Bits 26..24, always 0
    logic [`CHAN_DATA_W-1:0]                       data;  // Bits 23..0
  } out_word_t;

  typedef logic [$clog2(`NUM_CHAN)-1:0] chan_idx_t;  // Channel number 0..3

endpackage

//--- logic/regmap_pkg.sv
`include "readout_params.svh"

package regmap_pkg;

  // Byte offsets on the AXI4-Lite slave
  typedef enum logic [`AXI_ADDR_W-1:0] {
    REG_DATA    = 8'h00,  // RO, read pops one word
    REG_STATUS  = 8'h04,  // RO
    REG_CONTROL = 8'h08   // RW
  } reg_offset_e;

  typedef struct packed {
    logic [3:0]           zero_31;    // 31..28
    logic [`NUM_CHAN-1:0] overflow;   // 27..24, sticky per channel
    logic [3:0]           zero_23;    // 23..20
    logic                 rd_error;   // 19, sticky
    logic                 near_full;  // 18
    logic                 full;       // 17
    logic                 not_empty;  // 16
    logic [9:0]           zero_15;    // 15..6
    logic [5:0]           count;      // Output FIFO fill
  } status_t;

  typedef struct packed {
    logic [22:0]          zero_31;  // 31..9
    logic                 clear;    // Write 1 clears sticky flags
    logic [3:0]           zero_7;   // 7..4
    logic [`NUM_CHAN-1:0] enable;   // Channel enable mask
  } control_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

//--- logic/word_stream_if.sv
`include "readout_params.svh"

// Tagged word stream from the arbiter into the output FIFO
interface word_stream_if;

  logic                    valid;  // Word on offer
  logic                    ready;  // Output FIFO has room
  logic [`CHAN_DATA_W-1:0] data;   // Channel payload
  logic [`CHAN_ID_W-1:0]   chan;   // Identifier, index plus one
  logic                    last;   // End of packet

  modport source (
    output valid, data, chan, last,
    input  ready
  );

  modport sink (
    input  valid, data, chan, last,
    output ready
  );

endinterface

//--- logic/word_fifo.sv
`include "readout_params.svh"

module word_fifo #(
  parameter type payload_t = readout_pkg::chan_word_t,
  parameter int  depth     = `CHAN_FIFO_DEPTH
) (
  input  logic                           bus_clk,
  input  logic                           rst_n,
  input  logic                           push,
  input  payload_t                       push_data,
  input  logic                           pop,
  output payload_t                       pop_data,   // Head word, shown before pop
  output logic                           empty,
  output logic                           full,
  output logic [$clog2(depth+1)-1:0]     count
);

  localparam int AW = (depth > 1) ? $clog2(depth) : 1;  // Pointer width
  localparam int CW = $clog2(depth + 1);                // Fill count width

  payload_t        mem [depth];  // Storage ring
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;

  always_ff @(posedge bus_clk) begin
    if (push) mem[wr_ptr] <= push_data;  // Write port
  end

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == AW'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap at depth
      if (pop)  rd_ptr <= (rd_ptr == AW'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  assign pop_data = mem[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == CW'(depth));

  // Callers must respect the flags
  a_no_push_full: assert property (@(posedge bus_clk) disable iff (!rst_n) !(push && full));
  a_no_pop_empty: assert property (@(posedge bus_clk) disable iff (!rst_n) !(pop && empty));

endmodule

//--- logic/channel_buffers.sv
`include "readout_params.svh"

module channel_buffers (
  input  logic                                       bus_clk,
  input  logic                                       rst_n,
  input  logic [`NUM_CHAN-1:0]                       chan_valid,
  input  logic [`NUM_CHAN-1:0][`CHAN_DATA_W-1:0]     chan_data,
  input  logic [`NUM_CHAN-1:0]                       chan_last,
  input  logic [`NUM_CHAN-1:0]                       pop,         // One-hot from arbiter
  output readout_pkg::chan_word_t [`NUM_CHAN-1:0]    head,
  output logic [`NUM_CHAN-1:0]                       not_empty,
  input  logic                                       clear_sticky,
  output logic [`NUM_CHAN-1:0]                       overflow     // Sticky drop flags
);

  logic [`NUM_CHAN-1:0] full;
  logic [`NUM_CHAN-1:0] empty;
  logic [`NUM_CHAN-1:0] drop;  // Word lost this cycle

  for (genvar i = 0; i < `NUM_CHAN; i++) begin : g_chan
    readout_pkg::chan_word_t in_word;

    assign in_word.data = chan_data[i];
    assign in_word.last = chan_last[i];

    word_fifo #(
      .payload_t (readout_pkg::chan_word_t),
      .depth     (`CHAN_FIFO_DEPTH)
    ) u_fifo (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .push      (chan_valid[i] & ~full[i]),  // No back-pressure upstream
      .push_data (in_word),
      .pop       (pop[i]),
      .pop_data  (head[i]),
      .empty     (empty[i]),
      .full      (full[i]),
      .count     ()
    );
  end

  assign not_empty = ~empty;
  assign drop      = chan_valid & full;

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) overflow <= '0;
    else        overflow <= (overflow & {`NUM_CHAN{~clear_sticky}}) | drop;  // New drop wins
  end

  // Arbiter serves one channel at a time, and only a filled one
  a_pop_onehot: assert property (@(posedge bus_clk) disable iff (!rst_n) $onehot0(pop));
  a_pop_filled: assert property (@(posedge bus_clk) disable iff (!rst_n)
                                 (pop & ~not_empty) == '0);

endmodule

//--- logic/rr_arbiter.sv
`include "readout_params.svh"

module rr_arbiter (
  input  logic                                    bus_clk,
  input  logic                                    rst_n,
  input  logic [`NUM_CHAN-1:0]                    not_empty,
  input  readout_pkg::chan_word_t [`NUM_CHAN-1:0] head,
  output logic [`NUM_CHAN-1:0]                    pop,
  input  logic [`NUM_CHAN-1:0]                    enable,   // Sampled at packet start only
  word_stream_if.source                           out
);

  localparam int ID_W = `CHAN_ID_W;

  readout_pkg::chan_idx_t sel;          // Channel being served
  readout_pkg::chan_idx_t last_served;  // Search starts after this one
  readout_pkg::chan_idx_t next_sel;
  readout_pkg::chan_idx_t idx;
  logic                   active;       // Locked inside a packet
  logic                   found;
  logic                   xfer;

  ////////////////////////////////////////////////////////////
  // Round-robin search
  ////////////////////////////////////////////////////////////
  always_comb begin
    found    = 1'b0;
    next_sel = last_served;
    idx      = last_served;
    for (int k = 1; k <= `NUM_CHAN; k++) begin
      idx = readout_pkg::chan_idx_t'((int'(last_served) + k) % `NUM_CHAN);  // Upward, wrapping
      if (!found && enable[idx] && not_empty[idx]) begin
        found    = 1'b1;
        next_sel = idx;
      end
    end
  end

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      active      <= 1'b0;
      sel         <= '0;
      last_served <= readout_pkg::chan_idx_t'(`NUM_CHAN - 1);  // First search hits channel 0
    end else if (!active) begin
      if (found) begin
        sel    <= next_sel;
        active <= 1'b1;
      end
    end else if (xfer && head[sel].last) begin
      active      <= 1'b0;  // Packet done, pick again next cycle
      last_served <= sel;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stream side
  ////////////////////////////////////////////////////////////
  assign out.valid = active & not_empty[sel];  // Head is stable until we pop it
  assign out.data  = head[sel].data;
  assign out.last  = head[sel].last;
  assign out.chan  = ID_W'(sel) + 1'b1;        // Tag is index plus one
  assign xfer      = out.valid & out.ready;

  always_comb begin
    pop = '0;
    if (xfer) pop[sel] = 1'b1;  // Consume word as it moves
  end

  // Held word must not change while the output FIFO is full
  a_stream_hold: assert property (@(posedge bus_clk) disable iff (!rst_n)
    out.valid && !out.ready |=> out.valid && $stable({out.data, out.chan, out.last}));

endmodule

//--- logic/axil_readout.sv
`include "readout_params.svh"

module axil_readout (
  input  logic                     bus_clk,
  input  logic                     rst_n,
  word_stream_if.sink              in,
  input  logic [`AXI_ADDR_W-1:0]   awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [`AXI_DATA_W-1:0]   wdata,
  input  logic [`AXI_DATA_W/8-1:0] wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [`AXI_ADDR_W-1:0]   araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [`AXI_DATA_W-1:0]   rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready,
  output logic [`NUM_CHAN-1:0]     enable,
  output logic                     clear_sticky,  // One-cycle pulse
  input  logic [`NUM_CHAN-1:0]     overflow
);

  localparam int CW = $clog2(`OUT_FIFO_DEPTH + 1);

  readout_pkg::out_word_t push_word, fifo_head;
  regmap_pkg::status_t    status;
  regmap_pkg::control_t   ctl_rd, wr_ctl;
  regmap_pkg::axi_resp_e  rd_resp;
  logic [CW-1:0]          fifo_count;
  logic [`AXI_DATA_W-1:0] rd_mux;
  logic                   fifo_empty, fifo_full, fifo_pop;
  logic                   wr_go, ar_go, rd_error, rd_err_hit;

  ////////////////////////////////////////////////////////////
  // Output FIFO
  ////////////////////////////////////////////////////////////
  always_comb begin
    push_word      = '0;
    push_word.id   = in.chan;
    push_word.last = in.last;
    push_word.data = in.data;
  end

  assign in.ready = ~fifo_full;  // Arbiter holds its word when full

  word_fifo #(.payload_t(readout_pkg::out_word_t), .depth(`OUT_FIFO_DEPTH)) u_out_fifo (
    .bus_clk (bus_clk), .rst_n (rst_n),
    .push (in.valid & ~fifo_full), .push_data (push_word),
    .pop (fifo_pop), .pop_data (fifo_head),
    .empty (fifo_empty), .full (fifo_full), .count (fifo_count)
  );

  always_comb begin
    status           = '0;
    status.count     = fifo_count;
    status.not_empty = ~fifo_empty;
    status.full      = fifo_full;
    status.near_full = (fifo_count >= CW'(`NEAR_FULL_LEVEL));
    status.rd_error  = rd_error;
    status.overflow  = overflow;
    ctl_rd           = '0;
    ctl_rd.enable    = enable;  // Clear bit reads 0
  end

  ////////////////////////////////////////////////////////////
  // Read decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    rd_mux     = '0;
    rd_resp    = regmap_pkg::RESP_OKAY;
    rd_err_hit = 1'b0;
    case (araddr)
      regmap_pkg::REG_DATA: begin
        if (fifo_empty) begin
          rd_resp    = regmap_pkg::RESP_SLVERR;  // Underflow
          rd_err_hit = 1'b1;
        end else begin
          rd_mux = fifo_head;
        end
      end
      regmap_pkg::REG_STATUS:  rd_mux = status;
      regmap_pkg::REG_CONTROL: rd_mux = ctl_rd;
      default:                 rd_resp = regmap_pkg::RESP_SLVERR;  // Unmapped
    endcase
  end

  assign fifo_pop = ar_go & (araddr == regmap_pkg::REG_DATA) & ~fifo_empty;
  assign wr_ctl   = wdata;
  assign awready  = wr_go;  // Address and data taken together
  assign wready   = wr_go;
  assign arready  = ar_go;

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_go        <= 1'b0;
      ar_go        <= 1'b0;
      bvalid       <= 1'b0;
      bresp        <= regmap_pkg::RESP_OKAY;
      rvalid       <= 1'b0;
      rresp        <= regmap_pkg::RESP_OKAY;
      enable       <= '1;  // All channels on
      clear_sticky <= 1'b0;
      rd_error     <= 1'b0;
    end else begin
      wr_go        <= ~wr_go & ~bvalid & awvalid & wvalid;
      ar_go        <= ~ar_go & ~rvalid & arvalid;
      clear_sticky <= 1'b0;
      if (wr_go) begin
        bvalid <= 1'b1;
        bresp  <= regmap_pkg::RESP_SLVERR;  // Unless CONTROL below
        if (awaddr == regmap_pkg::REG_CONTROL) begin
          bresp <= regmap_pkg::RESP_OKAY;
          if (wstrb[0]) enable <= wr_ctl.enable;
          clear_sticky <= wstrb[1] & wr_ctl.clear;
        end
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (ar_go) begin
        rvalid <= 1'b1;
        rresp  <= rd_resp;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      rd_error <= (rd_error & ~clear_sticky) | (ar_go & rd_err_hit);  // Set wins
    end
  end

  always_ff @(posedge bus_clk) begin
    if (ar_go) rdata <= rd_mux;  // Held until next read
  end

endmodule

//--- logic/readout_top.sv
`include "readout_params.svh"

module readout_top (
  input  logic                                   bus_clk,
  input  logic                                   rst_n,
  input  logic [`NUM_CHAN-1:0]                   chan_valid,
  input  logic [`NUM_CHAN-1:0][`CHAN_DATA_W-1:0] chan_data,
  input  logic [`NUM_CHAN-1:0]                   chan_last,
  input  logic [`AXI_ADDR_W-1:0]                 awaddr,
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [`AXI_DATA_W-1:0]                 wdata,
  input  logic [`AXI_DATA_W/8-1:0]               wstrb,
  input  logic                                   wvalid,
  output logic                                   wready,
  output logic [1:0]                             bresp,
  output logic                                   bvalid,
  input  logic                                   bready,
  input  logic [`AXI_ADDR_W-1:0]                 araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  output logic [`AXI_DATA_W-1:0]                 rdata,
  output logic [1:0]                             rresp,
  output logic                                   rvalid,
  input  logic                                   rready
);

  readout_pkg::chan_word_t [`NUM_CHAN-1:0] head;  // Buffer heads to arbiter
  logic [`NUM_CHAN-1:0]                    not_empty;
  logic [`NUM_CHAN-1:0]                    pop;
  logic [`NUM_CHAN-1:0]                    enable;
  logic [`NUM_CHAN-1:0]                    overflow;
  logic                                    clear_sticky;

  word_stream_if u_stream ();  // Arbiter to output FIFO

  channel_buffers u_channel_buffers (
    .bus_clk (bus_clk), .rst_n (rst_n),
    .chan_valid (chan_valid), .chan_data (chan_data), .chan_last (chan_last),
    .pop (pop), .head (head), .not_empty (not_empty),
    .clear_sticky (clear_sticky), .overflow (overflow)
  );

  rr_arbiter u_rr_arbiter (
    .bus_clk (bus_clk), .rst_n (rst_n),
    .not_empty (not_empty), .head (head), .pop (pop),
    .enable (enable), .out (u_stream.source)
  );

  axil_readout u_axil_readout (
    .bus_clk (bus_clk), .rst_n (rst_n), .in (u_stream.sink),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .enable (enable), .clear_sticky (clear_sticky), .overflow (overflow)
  );

endmodule

//--- testbench/tb_readout_top.sv
`include "readout_params.svh"

module tb_readout_top;

  localparam int POLL_LIMIT = 400;                          // Cycles or polls per wait
  localparam int ID_W       = `CHAN_ID_W;
  localparam int CNT_W      = $clog2(`OUT_FIFO_DEPTH + 1);  // STATUS count field

  logic                                   bus_clk;
  logic                                   rst_n;
  logic [`NUM_CHAN-1:0]                   chan_valid;
  logic [`NUM_CHAN-1:0][`CHAN_DATA_W-1:0] chan_data;
  logic [`NUM_CHAN-1:0]                   chan_last;
  logic [`AXI_ADDR_W-1:0]                 awaddr;
  logic                                   awvalid;
  logic                                   awready;
  logic [`AXI_DATA_W-1:0]                 wdata;
  logic [`AXI_DATA_W/8-1:0]               wstrb;
  logic                                   wvalid;
  logic                                   wready;
  logic [1:0]                             bresp;
  logic                                   bvalid;
  logic                                   bready;
  logic [`AXI_ADDR_W-1:0]                 araddr;
  logic                                   arvalid;
  logic                                   arready;
  logic [`AXI_DATA_W-1:0]                 rdata;
  logic [1:0]                             rresp;
  logic                                   rvalid;
  logic                                   rready;

  readout_pkg::chan_word_t sent_q [`NUM_CHAN][$];  // Words sitting in each channel buffer
  readout_pkg::out_word_t  exp_q [$];              // Host read order still to come
  int                      rr_last;                // Last channel served by the arbiter
  logic [31:0]             lcg_state;
  string                   test_name;
  bit                      rd_is_data;             // Read in flight targets DATA

  readout_top u_readout_top (.*);

  initial begin
    bus_clk = 1'b0;
    forever #2 bus_clk = ~bus_clk;  // Period 4
  end

  ////////////////////////////////////////////////////////////
  // Reference and checks
  ////////////////////////////////////////////////////////////
  function automatic logic [`CHAN_DATA_W-1:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:8];  // Top 24 bits of the state
  endfunction

  function automatic readout_pkg::out_word_t expected_word(input int chan,
      input logic [`CHAN_DATA_W-1:0] data, input logic last);
    readout_pkg::out_word_t w;
    w      = '0;
    w.id   = ID_W'(chan + 1);  // Index plus one
    w.last = last;
    w.data = data;
    return w;
  endfunction

  task automatic stop_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout in %s: %s", test_name, what);
    stop_run();
  endtask

  task automatic check_word(input string name, input readout_pkg::out_word_t exp,
      input readout_pkg::out_word_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_status(input string name, input regmap_pkg::status_t exp,
      input regmap_pkg::status_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_resp(input string name, input regmap_pkg::axi_resp_e exp,
      input regmap_pkg::axi_resp_e act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  // Every DATA word the host receives is matched here
  always @(negedge bus_clk) begin : compare_data
    readout_pkg::out_word_t want;
    if (rvalid && rready && rd_is_data && rresp == regmap_pkg::RESP_OKAY) begin
      if (exp_q.size() == 0) begin
        $display("A DATA read returned a word while none was expected");
        stop_run();
      end else begin
        want = exp_q.pop_front();
        check_word(test_name, want, readout_pkg::out_word_t'(rdata));
      end
    end
  end

  // Walks the buffers in round-robin order one whole packet per visit
  task automatic expect_round_robin(input logic [`NUM_CHAN-1:0] mask);
    readout_pkg::chan_word_t w;
    int c;
    int sel;
    bit found;
    bit moving;
    found = 1'b1;
    sel   = 0;
    while (found) begin
      found = 1'b0;
      for (int k = 1; k <= `NUM_CHAN; k++) begin
        c = (rr_last + k) % `NUM_CHAN;  // Upward from the one after last served
        if (!found && mask[c] && sent_q[c].size() > 0) begin
          found = 1'b1;
          sel   = c;
        end
      end
      if (found) begin
        moving = 1'b1;
        while (moving) begin
          w = sent_q[sel].pop_front();
          exp_q.push_back(expected_word(sel, w.data, w.last));
          moving = !w.last && sent_q[sel].size() > 0;  // Stay until last
        end
        rr_last = sel;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus and channel drivers
  ////////////////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge bus_clk);
    #1;  // Drive point after the edge
  endtask

  task automatic send_beat(input logic [`NUM_CHAN-1:0] mask, input logic last, input bit keep);
    readout_pkg::chan_word_t w;
    for (int c = 0; c < `NUM_CHAN; c++) begin
      w.data        = next_rand();
      w.last        = last;
      chan_valid[c] = mask[c];
      chan_data[c]  = w.data;
      chan_last[c]  = w.last;
      if (mask[c] && keep) sent_q[c].push_back(w);  // Dropped words are not kept
    end
    next_cycle();
    chan_valid = '0;
  endtask

  task automatic axi_read(input logic [`AXI_ADDR_W-1:0] addr,
      output logic [`AXI_DATA_W-1:0] data, output regmap_pkg::axi_resp_e resp);
    int n;
    araddr     = addr;
    arvalid    = 1'b1;
    rready     = 1'b1;
    rd_is_data = (addr == regmap_pkg::REG_DATA);
    n = 0;
    while (!arready && n < POLL_LIMIT) begin
      next_cycle();
      n++;
    end
    if (!arready) report_timeout("arready never rose");
    next_cycle();  // Address taken on this edge
    arvalid = 1'b0;
    n = 0;
    while (!rvalid && n < POLL_LIMIT) begin
      next_cycle();
      n++;
    end
    if (!rvalid) report_timeout("rvalid never rose");
    data = rdata;
    resp = regmap_pkg::axi_resp_e'(rresp);
    next_cycle();
    rready     = 1'b0;
    rd_is_data = 1'b0;
  endtask

  task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr,
      input logic [`AXI_DATA_W-1:0] data, output regmap_pkg::axi_resp_e resp);
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    n = 0;
    while (!awready && n < POLL_LIMIT) begin
      next_cycle();
      n++;
    end
    if (!awready) report_timeout("awready never rose");
    if (wready !== 1'b1) begin
      $display("In %s wready did not rise together with awready", test_name);
      stop_run();
    end
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid && n < POLL_LIMIT) begin
      next_cycle();
      n++;
    end
    if (!bvalid) report_timeout("bvalid never rose");
    resp = regmap_pkg::axi_resp_e'(bresp);
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic write_control(input logic [`NUM_CHAN-1:0] enable, input logic clear);
    regmap_pkg::control_t  ctl;
    regmap_pkg::axi_resp_e r;
    ctl        = '0;
    ctl.enable = enable;
    ctl.clear  = clear;  // Sticky flags reset
    axi_write(regmap_pkg::REG_CONTROL, ctl, r);
    check_resp(test_name, regmap_pkg::RESP_OKAY, r);
  endtask

  task automatic read_status(output regmap_pkg::status_t st);
    logic [`AXI_DATA_W-1:0] d;
    regmap_pkg::axi_resp_e  r;
    axi_read(regmap_pkg::REG_STATUS, d, r);
    check_resp(test_name, regmap_pkg::RESP_OKAY, r);
    st = regmap_pkg::status_t'(d);
  endtask

  // Poll STATUS until full or until not-empty
  task automatic poll_status(input bit want_full, output regmap_pkg::status_t st);
    int n;
    n = 0;
    read_status(st);
    while (!(want_full ? st.full : st.not_empty) && n < POLL_LIMIT) begin
      read_status(st);
      n++;
    end
    if (!(want_full ? st.full : st.not_empty)) report_timeout("STATUS flag never set");
  endtask

  task automatic drain_expected();
    regmap_pkg::status_t    st;
    logic [`AXI_DATA_W-1:0] d;
    regmap_pkg::axi_resp_e  r;
    while (exp_q.size() > 0) begin
      poll_status(1'b0, st);
      axi_read(regmap_pkg::REG_DATA, d, r);  // Word checked by compare_data
      check_resp(test_name, regmap_pkg::RESP_OKAY, r);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    regmap_pkg::status_t    st;
    regmap_pkg::status_t    exp_st;
    logic [`AXI_DATA_W-1:0] d;
    regmap_pkg::axi_resp_e  r;
    rst_n      = 1'b0;
    chan_valid = '0;
    chan_data  = '0;
    chan_last  = '0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    rd_is_data = 1'b0;
    lcg_state  = 32'd39540;
    rr_last    = `NUM_CHAN - 1;  // First search lands on channel 0
    test_name  = "reset";
    repeat (16) @(posedge bus_clk);
    #1 rst_n = 1'b1;

    test_name = "single channel";
    for (int i = 0; i < 6; i++) send_beat(4'b0100, 1'b1, 1'b1);
    expect_round_robin(4'hF);
    drain_expected();

    test_name = "round robin";
    write_control(4'h0, 1'b0);  // Hold everything in the buffers
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < 3; i++) send_beat(4'hF, i == 2, 1'b1);
    end
    write_control(4'hF, 1'b0);
    expect_round_robin(4'hF);
    drain_expected();

    test_name = "overflow";
    write_control(4'h0, 1'b0);
    for (int i = 0; i < 10; i++) send_beat(4'b0010, 1'b1, i < `CHAN_FIFO_DEPTH);
    exp_st          = '0;
    exp_st.overflow = 4'b0010;
    read_status(st);
    check_status(test_name, exp_st, st);
    write_control(4'b0010, 1'b0);
    expect_round_robin(4'b0010);
    drain_expected();
    write_control(4'hF, 1'b1);
    exp_st = '0;  // Flag gone and nothing left over
    read_status(st);
    check_status(test_name, exp_st, st);

    test_name = "output full";
    write_control(4'h0, 1'b0);
    for (int i = 0; i < `CHAN_FIFO_DEPTH; i++) send_beat(4'hF, i % 4 == 3, 1'b1);
    write_control(4'hF, 1'b0);
    poll_status(1'b1, st);
    exp_st           = '0;
    exp_st.count     = CNT_W'(`OUT_FIFO_DEPTH);
    exp_st.not_empty = 1'b1;
    exp_st.full      = 1'b1;
    exp_st.near_full = 1'b1;
    read_status(st);
    check_status(test_name, exp_st, st);
    expect_round_robin(4'hF);
    drain_expected();
    exp_st = '0;
    read_status(st);
    check_status(test_name, exp_st, st);

    test_name = "error response";
    axi_read(regmap_pkg::REG_DATA, d, r);  // Underflow
    check_resp(test_name, regmap_pkg::RESP_SLVERR, r);
    exp_st          = '0;
    exp_st.rd_error = 1'b1;
    read_status(st);
    check_status(test_name, exp_st, st);
    write_control(4'hF, 1'b1);
    exp_st = '0;
    read_status(st);
    check_status(test_name, exp_st, st);
    axi_read(8'h0C, d, r);  // Unmapped
    check_resp(test_name, regmap_pkg::RESP_SLVERR, r);

    $display("sim passed");
    $finish;
  end

endmodule

//--- readout_top.f
+incdir+include
logic/readout_pkg.sv
logic/regmap_pkg.sv
logic/word_stream_if.sv
logic/word_fifo.sv
logic/channel_buffers.sv
logic/rr_arbiter.sv
logic/axil_readout.sv
logic/readout_top.sv
testbench/tb_readout_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_readout_top
RTL_TOP   = readout_top
FILELIST  = readout_top.f
OBJ_DIR   = obj_dir
SIM_BIN   = sim_$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN) | tee /dev/stderr | grep -q "sim passed"

clean:
	rm -rf $(OBJ_DIR)
